// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = frontend_tb
FILELIST = verilog.f
OBJ      = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ)

# pass only if the log holds the pass line
run: build
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(SIM) --lint-only --timing --timescale 1ns/1ps -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ) $(LOG)

// ==== logic/banked_inst_mem.sv ====
`default_nettype none

module banked_inst_mem #(
    parameter int mem_words = 256
) (
    input  logic                            clk,
    fetch_if.memory                         fetch,
    input  logic                            prog_we,
    input  logic [cpu_word_pkg::word_w-1:0] prog_addr,
    input  logic [cpu_word_pkg::word_w-1:0] prog_data
);

    localparam int lanes      = fetch.decode_para;
    localparam int bank_words = mem_words / 2;
    localparam int aw         = $clog2(bank_words);

    // bank picked by PC bit 2, even words in bank 0
    logic [cpu_word_pkg::word_w-1:0] bank0 [bank_words];
    logic [cpu_word_pkg::word_w-1:0] bank1 [bank_words];

    logic [aw-1:0] prog_idx;

    assign prog_idx = prog_addr[aw+2:3];

    always_ff @(posedge clk) begin
        if (prog_we) begin
            if (prog_addr[2]) begin
                bank1[prog_idx] <= prog_data;
            end else begin
                bank0[prog_idx] <= prog_data;
            end
        end
    end

    // one read port per bank and cycle, lower lanes win
    always_comb begin
        logic [1:0] busy;
        busy = 2'b00;
        for (int d = 0; d < lanes; d++) begin
            logic          bank;
            logic [aw-1:0] idx;
            bank = fetch.pc[d][2];
            idx  = fetch.pc[d][aw+2:3];
            fetch.done[d] = fetch.order[d] & ~busy[bank];
            if (fetch.done[d]) begin
                busy[bank] = 1'b1;
            end
            fetch.instr[d] = bank ? bank1[idx] : bank0[idx];
        end
    end

    a_done_needs_order: assert property (
        @(posedge clk) (fetch.done & ~fetch.order) == '0
    );

endmodule

`default_nettype wire

// ==== logic/context_manager.sv ====
`default_nettype none

module context_manager #(
    parameter int decode_para = context_pkg::decode_para_default
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    fetch_if.requester                                  fetch,
    input  logic [decode_para-1:0]                      window_ready,
    output logic [decode_para-1:0]                      issue_valid,
    output cpu_word_pkg::issue_rec_t [decode_para-1:0]  issue_rec,
    input  logic                                        exec_jump,
    input  logic [cpu_word_pkg::word_w-1:0]             exec_jump_pc,
    input  logic                                        exec_branch,
    input  logic [context_pkg::n_contexts-1:0]          exec_branch_context,
    input  logic                                        exec_branch_hazard,
    output logic                                        branch_hazard,
    output logic [context_pkg::n_contexts-1:0]          hazard_context_info
);

    localparam int nc = context_pkg::n_contexts;
    localparam int ww = cpu_word_pkg::word_w;

    function automatic logic [nc-1:0] rotl(input logic [nc-1:0] ctx);
        return {ctx[nc-2:0], ctx[nc-1]};
    endfunction

    function automatic logic [nc-1:0][ww-1:0] set_recovery(
        input logic [nc-1:0][ww-1:0] rpc,
        input logic [nc-1:0]         ctx,
        input logic [ww-1:0]         pc
    );
        logic [nc-1:0][ww-1:0] res;
        res = rpc;
        for (int c = 0; c < nc; c++) begin
            if (ctx[c]) begin
                res[c] = pc;
            end
        end
        return res;
    endfunction

    // kill-set update when old_ctx branches into new_ctx
    function automatic logic [nc-1:0][nc-1:0] open_context(
        input logic [nc-1:0][nc-1:0] kill,
        input logic [nc-1:0]         old_ctx,
        input logic [nc-1:0]         new_ctx
    );
        logic [nc-1:0][nc-1:0] res;
        for (int c = 0; c < nc; c++) begin
            if (new_ctx[c]) begin
                res[c] = '0;
            end else if (old_ctx[c]) begin
                res[c] = new_ctx;
            end else if (|(kill[c] & old_ctx)) begin
                // ancestors of the old context lose the new one too
                res[c] = kill[c] | new_ctx;
            end else begin
                res[c] = kill[c];
            end
        end
        return res;
    endfunction

    logic [nc-1:0]         hot_context;
    logic [ww-1:0]         hot_pc;
    logic                  hot_unfetched;
    logic [nc-1:0][ww-1:0] recovery_pc;
    logic [nc-1:0][nc-1:0] kill_set;

    logic [nc-1:0]         sel_kill;
    logic [ww-1:0]         sel_pc;
    logic [nc-1:0][nc-1:0] kill_1;

    // lane chain, entry 0 is the state after execute results
    logic [nc-1:0]         ctx_c  [decode_para+1];
    logic [ww-1:0]         pc_c   [decode_para+1];
    logic [nc-1:0][ww-1:0] rpc_c  [decode_para+1];
    logic [nc-1:0][nc-1:0] kill_c [decode_para+1];
    logic [decode_para:0]  unf_c;
    logic [decode_para:0]  ok_c;

    // look up the resolved context
    always_comb begin
        sel_kill = '0;
        sel_pc   = '0;
        for (int c = 0; c < nc; c++) begin
            if (exec_branch_context[c]) begin
                sel_kill = sel_kill | kill_set[c];
                sel_pc   = sel_pc | recovery_pc[c];
            end
        end
    end

    assign branch_hazard       = exec_branch & exec_branch_hazard;
    assign hazard_context_info = branch_hazard ? sel_kill : '0;

    always_comb begin
        for (int c = 0; c < nc; c++) begin
            if (hazard_context_info[c]) begin
                kill_1[c] = '0;
            end else if (exec_branch) begin
                // resolved context is no longer anyone's to kill
                kill_1[c] = kill_set[c] & ~exec_branch_context;
            end else begin
                kill_1[c] = kill_set[c];
            end
        end
    end

    assign ctx_c[0]  = branch_hazard ? rotl(hot_context) : hot_context;
    assign pc_c[0]   = branch_hazard ? sel_pc :
                       exec_jump     ? exec_jump_pc :
                                       hot_pc;
    assign unf_c[0]  = branch_hazard | exec_jump | hot_unfetched;
    assign rpc_c[0]  = recovery_pc;
    assign kill_c[0] = kill_1;

    // nothing is ordered while reset is held
    assign ok_c[0] = rst_n;

    assign issue_valid = fetch.done;

    for (genvar d = 0; d < decode_para; d++) begin : g_lane
        logic          branch;
        logic          next_ready;
        logic [ww-1:0] next_pc;
        logic [ww-1:0] alt_pc;
        logic [nc-1:0] new_ctx;

        assign fetch.order[d] = unf_c[d] & window_ready[d] & ok_c[d];
        assign fetch.pc[d]    = pc_c[d];

        // a stalled or refused lane holds every later lane
        assign ok_c[d+1] = ok_c[d] & window_ready[d] & (~fetch.order[d] | fetch.done[d]);

        inst_decoder u_dec (
            .valid        (fetch.done[d]),
            .instr        (fetch.instr[d]),
            .pc           (pc_c[d]),
            .hot_context  (ctx_c[d]),
            .rec          (issue_rec[d]),
            .next_pc_ready(next_ready),
            .branch       (branch),
            .next_pc      (next_pc),
            .alt_pc       (alt_pc)
        );

        assign new_ctx = rotl(ctx_c[d]);

        assign ctx_c[d+1]  = branch ? new_ctx : ctx_c[d];
        assign pc_c[d+1]   = fetch.done[d] ? next_pc : pc_c[d];
        assign unf_c[d+1]  = fetch.done[d] ? next_ready : unf_c[d];
        assign rpc_c[d+1]  = branch ? set_recovery(rpc_c[d], ctx_c[d], alt_pc) : rpc_c[d];
        assign kill_c[d+1] = branch ? open_context(kill_c[d], ctx_c[d], new_ctx) : kill_c[d];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hot_context   <= context_pkg::context_init;
            hot_pc        <= '0;
            hot_unfetched <= 1'b1;
            kill_set      <= '0;
        end else begin
            hot_context   <= ctx_c[decode_para];
            hot_pc        <= pc_c[decode_para];
            hot_unfetched <= unf_c[decode_para];
            kill_set      <= kill_c[decode_para];
        end
    end

    always_ff @(posedge clk) begin
        recovery_pc <= rpc_c[decode_para];
    end

    a_hot_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot(hot_context)
    );

    a_exec_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) exec_branch |-> $onehot(exec_branch_context)
    );

    for (genvar c = 0; c < nc; c++) begin : g_kill_chk
        a_no_self_kill: assert property (
            @(posedge clk) disable iff (!rst_n) !kill_set[c][c]
        );
    end

endmodule

`default_nettype wire

// ==== logic/context_pkg.sv ====
`default_nettype none

package context_pkg;

    // one-hot contexts, one per unresolved branch
    localparam int n_contexts = 8;

    // context in use right after reset
    localparam logic [n_contexts-1:0] context_init = {{(n_contexts-1){1'b0}}, 1'b1};

    // lanes fetched and decoded per cycle
    localparam int decode_para_default = 2;

endpackage

`default_nettype wire

// ==== logic/cpu_word_pkg.sv ====
`default_nettype none

package cpu_word_pkg;

    localparam int word_w = 32;

    // byte distance between consecutive instructions
    localparam logic [word_w-1:0] pc_step = 32'd4;

    typedef enum logic [3:0] {
        op_alu = 4'h0,
        op_br  = 4'h1,
        op_jmp = 4'h2,
        op_jr  = 4'h3
    } opcode_e;

    // same word read as branch or as jump, opcode sits in the top nibble of both
    typedef union packed {
        struct packed {
            opcode_e            opcode;
            logic [11:0]        unused;
            logic signed [15:0] offset;
        } br;
        struct packed {
            opcode_e     opcode;
            logic [27:0] target;
        } jmp;
    } inst_u;

    // what the instruction window receives per lane
    typedef struct packed {
        logic [word_w-1:0]                 pc;
        inst_u                             instr;
        logic                              branch;
        logic [context_pkg::n_contexts-1:0] cntx;
    } issue_rec_t;

endpackage

`default_nettype wire

// ==== logic/fetch_if.sv ====
`default_nettype none

interface fetch_if #(
    parameter int decode_para = context_pkg::decode_para_default
);

    // one bit per lane
    logic [decode_para-1:0] order;
    logic [decode_para-1:0] done;

    // one word per lane
    logic [decode_para-1:0][cpu_word_pkg::word_w-1:0] pc;
    cpu_word_pkg::inst_u [decode_para-1:0]            instr;

    modport requester (
        output order,
        output pc,
        input  done,
        input  instr
    );

    modport memory (
        input  order,
        input  pc,
        output done,
        output instr
    );

endinterface

`default_nettype wire

// ==== logic/frontend_top.sv ====
`default_nettype none

module frontend_top #(
    parameter int decode_para = context_pkg::decode_para_default,
    parameter int mem_words   = 256
) (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              prog_we,
    input  logic [cpu_word_pkg::word_w-1:0]                   prog_addr,
    input  logic [cpu_word_pkg::word_w-1:0]                   prog_data,
    input  logic [decode_para-1:0]                            window_ready,
    output logic [decode_para-1:0]                            issue_valid,
    output logic [decode_para-1:0][cpu_word_pkg::word_w-1:0]  issue_pc,
    output logic [decode_para-1:0][cpu_word_pkg::word_w-1:0]  issue_instr,
    output logic [decode_para-1:0]                            issue_branch,
    output logic [decode_para-1:0][context_pkg::n_contexts-1:0] issue_context,
    input  logic                                              exec_jump,
    input  logic [cpu_word_pkg::word_w-1:0]                   exec_jump_pc,
    input  logic                                              exec_branch,
    input  logic [context_pkg::n_contexts-1:0]                exec_branch_context,
    input  logic                                              exec_branch_hazard,
    output logic                                              branch_hazard,
    output logic [context_pkg::n_contexts-1:0]                hazard_context_info
);

    cpu_word_pkg::issue_rec_t [decode_para-1:0] issue_rec;

    fetch_if #(.decode_para(decode_para)) u_fetch ();

    context_manager #(
        .decode_para(decode_para)
    ) u_ctx (
        .clk                (clk),
        .rst_n              (rst_n),
        .fetch              (u_fetch.requester),
        .window_ready       (window_ready),
        .issue_valid        (issue_valid),
        .issue_rec          (issue_rec),
        .exec_jump          (exec_jump),
        .exec_jump_pc       (exec_jump_pc),
        .exec_branch        (exec_branch),
        .exec_branch_context(exec_branch_context),
        .exec_branch_hazard (exec_branch_hazard),
        .branch_hazard      (branch_hazard),
        .hazard_context_info(hazard_context_info)
    );

    banked_inst_mem #(
        .mem_words(mem_words)
    ) u_mem (
        .clk      (clk),
        .fetch    (u_fetch.memory),
        .prog_we  (prog_we),
        .prog_addr(prog_addr),
        .prog_data(prog_data)
    );

    // record split into plain per-lane fields for the window
    for (genvar d = 0; d < decode_para; d++) begin : g_issue
        assign issue_pc[d]      = issue_rec[d].pc;
        assign issue_instr[d]   = issue_rec[d].instr;
        assign issue_branch[d]  = issue_rec[d].branch;
        assign issue_context[d] = issue_rec[d].cntx;
    end

endmodule

`default_nettype wire

// ==== logic/inst_decoder.sv ====
`default_nettype none

module inst_decoder (
    input  logic                                    valid,
    input  cpu_word_pkg::inst_u                     instr,
    input  logic [cpu_word_pkg::word_w-1:0]         pc,
    input  logic [context_pkg::n_contexts-1:0]      hot_context,
    output cpu_word_pkg::issue_rec_t                rec,
    output logic                                    next_pc_ready,
    output logic                                    branch,
    output logic [cpu_word_pkg::word_w-1:0]         next_pc,
    output logic [cpu_word_pkg::word_w-1:0]         alt_pc
);

    logic [cpu_word_pkg::word_w-1:0] seq_pc;
    logic [cpu_word_pkg::word_w-1:0] br_target;
    logic [cpu_word_pkg::word_w-1:0] jmp_target;
    logic                            taken;

    assign seq_pc = pc + cpu_word_pkg::pc_step;

    // word offset, sign extended and scaled to bytes
    assign br_target = pc + {{14{instr.br.offset[15]}}, instr.br.offset, 2'b00};

    assign jmp_target = {2'b00, instr.jmp.target, 2'b00};

    // static prediction: backward taken, forward not taken
    assign taken = instr.br.offset[15];

    always_comb begin
        next_pc_ready = 1'b1;
        branch        = 1'b0;
        next_pc       = seq_pc;
        alt_pc        = seq_pc;
        case (instr.br.opcode)
            cpu_word_pkg::op_br: begin
                branch  = valid;
                next_pc = taken ? br_target : seq_pc;
                alt_pc  = taken ? seq_pc : br_target;
            end
            cpu_word_pkg::op_jmp: begin
                next_pc = jmp_target;
            end
            cpu_word_pkg::op_jr: begin
                // target only known after execute
                next_pc_ready = 1'b0;
            end
            default: begin
                next_pc = seq_pc;
            end
        endcase
    end

    // the branch itself still belongs to the context it was fetched in
    assign rec = '{
        pc:     pc,
        instr:  instr,
        branch: branch,
        cntx:   hot_context
    };

endmodule

`default_nettype wire

// ==== tests/frontend_tb.sv ====
`default_nettype none

module frontend_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int lanes        = 2;
    localparam int mem_words    = 256;
    localparam int nc           = context_pkg::n_contexts;
    localparam int ww           = cpu_word_pkg::word_w;
    localparam int reset_cycles = 16;
    localparam int issue_goal   = 3000;
    localparam int max_cycles   = 60000;
    localparam int stall_limit  = 200;

    logic                     clk;
    logic                     rst_n;
    logic                     prog_we;
    logic [ww-1:0]            prog_addr;
    logic [ww-1:0]            prog_data;
    logic [lanes-1:0]         window_ready;
    logic [lanes-1:0]         issue_valid;
    logic [lanes-1:0][ww-1:0] issue_pc;
    logic [lanes-1:0][ww-1:0] issue_instr;
    logic [lanes-1:0]         issue_branch;
    logic [lanes-1:0][nc-1:0] issue_context;
    logic                     exec_jump;
    logic [ww-1:0]            exec_jump_pc;
    logic                     exec_branch;
    logic [nc-1:0]            exec_branch_context;
    logic                     exec_branch_hazard;
    logic                     branch_hazard;
    logic [nc-1:0]            hazard_context_info;

    logic [ww-1:0] prog [mem_words];
    logic [31:0]   lfsr;

    // reference model, contexts kept as indices
    int            m_ctx;
    logic [ww-1:0] m_pc;
    logic          m_unf;
    logic [ww-1:0] m_rpc  [nc];
    logic [nc-1:0] m_kill [nc];

    // outstanding branches, oldest first
    int   br_ctx [$];
    int   br_due [$];
    logic jr_wait;
    int   jr_due;
    int   cyc;
    int   issued;
    int   last_issue;

    frontend_top #(
        .decode_para(lanes),
        .mem_words  (mem_words)
    ) UUT (
        .clk                (clk),
        .rst_n              (rst_n),
        .prog_we            (prog_we),
        .prog_addr          (prog_addr),
        .prog_data          (prog_data),
        .window_ready       (window_ready),
        .issue_valid        (issue_valid),
        .issue_pc           (issue_pc),
        .issue_instr        (issue_instr),
        .issue_branch       (issue_branch),
        .issue_context      (issue_context),
        .exec_jump          (exec_jump),
        .exec_jump_pc       (exec_jump_pc),
        .exec_branch        (exec_branch),
        .exec_branch_context(exec_branch_context),
        .exec_branch_hazard (exec_branch_hazard),
        .branch_hazard      (branch_hazard),
        .hazard_context_info(hazard_context_info)
    );

    always #5 clk = ~clk;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd000_0001) : (lfsr >> 1);
        end
        return val;
    endfunction

    // mostly alu, some branches both ways, jumps and a rare jr
    function automatic logic [ww-1:0] gen_word();
        logic [3:0]  kind;
        logic [15:0] off;
        kind = 4'(take_bits(4));
        off  = 16'(take_bits(3)) + 16'd1;
        if (kind < 4'd9) begin
            return {cpu_word_pkg::op_alu, 28'(take_bits(28))};
        end else if (kind < 4'd11) begin
            return {cpu_word_pkg::op_br, 12'(take_bits(12)), off};
        end else if (kind < 4'd13) begin
            return {cpu_word_pkg::op_br, 12'(take_bits(12)), -off};
        end else if (kind < 4'd15) begin
            return {cpu_word_pkg::op_jmp, 20'd0, 8'(take_bits(8))};
        end else begin
            return {cpu_word_pkg::op_jr, 28'(take_bits(28))};
        end
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // window and execute stand-ins
    task automatic drive_inputs();
        exec_branch         = 1'b0;
        exec_branch_hazard  = 1'b0;
        exec_branch_context = '0;
        exec_jump           = 1'b0;
        exec_jump_pc        = '0;
        if (br_ctx.size() > 0 && cyc >= br_due[0]) begin
            exec_branch                    = 1'b1;
            exec_branch_context[br_ctx[0]] = 1'b1;
            exec_branch_hazard             = (take_bits(2) == 32'd0);
        end else if (jr_wait && cyc >= jr_due) begin
            exec_jump    = 1'b1;
            exec_jump_pc = {22'd0, 8'(take_bits(8)), 2'b00};
        end
        window_ready = lanes'(take_bits(lanes));
        // keep free contexts for every lane
        if (br_ctx.size() + lanes >= nc) begin
            window_ready = '0;
        end
    endtask

    task automatic evaluate_cycle();
        logic          hz;
        logic [nc-1:0] info;
        logic [nc-1:0] oh;
        logic [ww-1:0] pc;
        logic [ww-1:0] w;
        logic [ww-1:0] seq;
        logic [ww-1:0] tgt;
        logic [1:0]    busy;
        logic          unf;
        logic          ok;
        logic          order;
        logic          done;
        int            ctx;
        int            nxt;
        int            rc;

        rc = 0;
        if (exec_branch) begin
            rc = br_ctx[0];
        end
        hz   = exec_branch & exec_branch_hazard;
        info = hz ? m_kill[rc] : '0;
        check("branch_hazard", 64'(branch_hazard), 64'(hz));
        check("hazard_context_info", 64'(hazard_context_info), 64'(info));

        // execute results apply before this cycle's fetch
        for (int c = 0; c < nc; c++) begin
            if (info[c]) begin
                m_kill[c] = '0;
            end else if (exec_branch) begin
                m_kill[c][rc] = 1'b0;
            end
        end
        ctx = hz ? (m_ctx + 1) % nc : m_ctx;
        pc  = hz ? m_rpc[rc] : (exec_jump ? exec_jump_pc : m_pc);
        unf = hz | exec_jump | m_unf;
        if (hz) begin
            br_ctx.delete();
            br_due.delete();
            jr_wait = 1'b0;
        end else if (exec_branch) begin
            void'(br_ctx.pop_front());
            void'(br_due.pop_front());
        end
        if (exec_jump) begin
            jr_wait = 1'b0;
        end

        ok   = 1'b1;
        busy = 2'b00;
        for (int d = 0; d < lanes; d++) begin
            order = unf & window_ready[d] & ok;
            // banks interleave on pc bit 2
            done = order & ~busy[pc[2]];
            check($sformatf("issue_valid[%0d]", d), 64'(issue_valid[d]), 64'(done));
            ok = ok & window_ready[d] & (~order | done);
            if (done) begin
                busy[pc[2]] = 1'b1;
                w           = prog[pc[9:2]];
                oh          = '0;
                oh[ctx]     = 1'b1;
                if (issued == 0) begin
                    check("first issue_context", 64'(issue_context[d]),
                          64'(context_pkg::context_init));
                end
                check($sformatf("issue_pc[%0d]", d), 64'(issue_pc[d]), 64'(pc));
                check($sformatf("issue_instr[%0d]", d), 64'(issue_instr[d]), 64'(w));
                check($sformatf("issue_context[%0d]", d), 64'(issue_context[d]), 64'(oh));
                check($sformatf("issue_branch[%0d]", d), 64'(issue_branch[d]),
                      64'(w[31:28] == cpu_word_pkg::op_br));
                issued++;
                last_issue = cyc;
                seq = pc + 32'd4;
                if (w[31:28] == cpu_word_pkg::op_br) begin
                    tgt        = pc + 32'($signed(w[15:0]) * 4);
                    m_rpc[ctx] = w[15] ? seq : tgt;
                    pc         = w[15] ? tgt : seq;
                    nxt        = (ctx + 1) % nc;
                    // whoever kills ctx also kills its successor
                    for (int c = 0; c < nc; c++) begin
                        if (m_kill[c][ctx]) begin
                            m_kill[c][nxt] = 1'b1;
                        end
                    end
                    m_kill[ctx]      = '0;
                    m_kill[ctx][nxt] = 1'b1;
                    m_kill[nxt]      = '0;
                    br_ctx.push_back(ctx);
                    br_due.push_back(cyc + 1 + int'(take_bits(3)));
                    ctx = nxt;
                end else if (w[31:28] == cpu_word_pkg::op_jmp) begin
                    pc = 32'(w[27:0]) << 2;
                end else if (w[31:28] == cpu_word_pkg::op_jr) begin
                    unf     = 1'b0;
                    jr_wait = 1'b1;
                    jr_due  = cyc + 1 + int'(take_bits(2));
                    pc      = seq;
                end else begin
                    pc = seq;
                end
            end
        end
        m_ctx = ctx;
        m_pc  = pc;
        m_unf = unf;
    endtask

    initial begin
        clk                 = 1'b0;
        rst_n               = 1'b0;
        prog_we             = 1'b0;
        prog_addr           = '0;
        prog_data           = '0;
        window_ready        = '0;
        exec_jump           = 1'b0;
        exec_jump_pc        = '0;
        exec_branch         = 1'b0;
        exec_branch_context = '0;
        exec_branch_hazard  = 1'b0;
        lfsr                = 32'he4eecb5a;
        jr_wait             = 1'b0;
        jr_due              = 0;
        m_ctx               = 0;
        m_pc                = '0;
        m_unf               = 1'b1;
        for (int c = 0; c < nc; c++) begin
            m_kill[c] = '0;
            m_rpc[c]  = '0;
        end
        for (int a = 0; a < mem_words; a++) begin
            prog[a] = gen_word();
        end

        // program load starts in reset and ends with the window still closed
        for (int a = 0; a < mem_words; a++) begin
            @(negedge clk);
            if (a == reset_cycles) begin
                rst_n = 1'b1;
            end
            prog_we   = 1'b1;
            prog_addr = 32'(a * 4);
            prog_data = prog[a];
            #2;
            check(rst_n ? "issue_valid while loading" : "issue_valid in reset",
                  64'(issue_valid), 64'(0));
        end
        @(negedge clk);
        prog_we = 1'b0;
        #2;
        check("issue_valid while loading", 64'(issue_valid), 64'(0));

        cyc        = 0;
        issued     = 0;
        last_issue = 0;
        while (issued < issue_goal && cyc < max_cycles) begin
            @(negedge clk);
            drive_inputs();
            #2;
            evaluate_cycle();
            if (cyc - last_issue > stall_limit) begin
                $display("no instruction issued for %0d cycles at t=%0t", stall_limit, $time);
                $display("TEST RESULT: FAIL");
                $fatal(1, "issue stalled");
            end
            cyc++;
        end

        if (issued >= issue_goal) begin
            $display("%0d instructions issued in %0d cycles", issued, cyc);
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("cycle limit reached with only %0d instructions issued", issued);
            $display("TEST RESULT: FAIL");
            $fatal(1, "cycle limit reached");
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/context_pkg.sv
logic/cpu_word_pkg.sv
logic/fetch_if.sv
logic/inst_decoder.sv
logic/context_manager.sv
logic/banked_inst_mem.sv
logic/frontend_top.sv
tests/frontend_tb.sv
